// ==== logic/rw_gen_pkg.sv ====
package rw_gen_pkg;

    // ----------------------------------------------------------------------
    // Widths
    // ----------------------------------------------------------------------
    localparam int ADDR_W  = 32;
    localparam int DATA_W  = 32;
    localparam int SEQ_W   = 8;
    localparam int COUNT_W = 16;

    // ----------------------------------------------------------------------
    // Enums
    // ----------------------------------------------------------------------
    // Gather reads, scatter writes
    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

    typedef enum logic [2:0] {
        GEN_IDLE  = 3'd0,
        GEN_START = 3'd1,
        GEN_BUSY  = 3'd2,
        GEN_PAUSE = 3'd3,
        GEN_DRAIN = 3'd4,
        GEN_DONE  = 3'd5
    } gen_state_e;

    // ----------------------------------------------------------------------
    // Packed structs
    // ----------------------------------------------------------------------
    // One configuration beat, shift is log2 of the element size
    typedef struct packed {
        logic [ADDR_W-1:0]  base_addr;
        logic [1:0]         shift;
        mem_op_e            op;
        logic [COUNT_W-1:0] count;
    } gen_config_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [SEQ_W-1:0]  seq_id;
    } engine_beat_t;

    typedef struct packed {
        mem_op_e           op;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [SEQ_W-1:0]  seq_id;
    } mem_req_t;

    // Response keeps the seq_id of its request
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [SEQ_W-1:0]  seq_id;
    } mem_resp_t;

endpackage : rw_gen_pkg

// ==== logic/packet_fifo.sv ====
`timescale 1ns/1ps

module packet_fifo #(
    parameter type entry_t     = logic,
    parameter int  FIFO_DEPTH  = 16,
    parameter int  PROG_THRESH = 8
) (
    input  logic   ap_clk,
    input  logic   areset_generator,
    input  entry_t din,
    input  logic   push,
    input  logic   pop,
    output entry_t dout,
    output logic   empty,
    output logic   full,
    output logic   prog_full
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int OCC_W = $clog2(FIFO_DEPTH + 1);

    entry_t             mem [FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [OCC_W-1:0]   occupancy;

    // Wrap at the last slot, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // ----------------------------------------------------------------------
    // Storage
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    // Head read straight from the array
    assign dout = mem[rd_ptr];

    // ----------------------------------------------------------------------
    // Pointers and occupancy
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({push, pop})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

    assign empty     = (occupancy == '0);
    assign full      = (occupancy == OCC_W'(FIFO_DEPTH));
    assign prog_full = (occupancy >= OCC_W'(PROG_THRESH));

    // Overflow and underflow would corrupt the pointers silently
    assert property (@(posedge ap_clk) disable iff (areset_generator)
        push |-> !full)
        else $error("packet_fifo: push while full");

    assert property (@(posedge ap_clk) disable iff (areset_generator)
        pop |-> !empty)
        else $error("packet_fifo: pop while empty");

endmodule : packet_fifo

// ==== logic/outstanding_counter.sv ====
`timescale 1ns/1ps

module outstanding_counter #(
    parameter int CNT_W = 8
) (
    input  logic ap_clk,
    input  logic areset_generator,
    input  logic incr,
    input  logic decr,
    output logic is_zero
);

    logic [CNT_W-1:0] count;

    // Simultaneous incr and decr leave the count alone
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            count <= '0;
        end else if (incr && !decr) begin
            count <= count + 1'b1;
        end else if (decr && !incr) begin
            count <= count - 1'b1;
        end
    end

    assign is_zero = (count == '0);

    // A response with no read in flight
    assert property (@(posedge ap_clk) disable iff (areset_generator)
        (decr && !incr) |-> !is_zero)
        else $error("outstanding_counter: decrement at zero");

    assert property (@(posedge ap_clk) disable iff (areset_generator)
        (incr && !decr) |-> (count != '1))
        else $error("outstanding_counter: increment at maximum");

endmodule : outstanding_counter

// ==== logic/rw_kernel.sv ====
`timescale 1ns/1ps

module rw_kernel
    import rw_gen_pkg::*;
(
    input  logic         ap_clk,
    input  logic         areset_generator,
    input  gen_config_t  cfg,
    input  engine_beat_t beat,
    input  logic         take,
    output mem_req_t     req,
    output logic         req_valid
);

    logic [ADDR_W-1:0] index;
    logic [ADDR_W-1:0] addr_int;
    logic [DATA_W-1:0] data_int;

    // ----------------------------------------------------------------------
    // Address and data
    // ----------------------------------------------------------------------
    always_comb begin
        if (cfg.op == MEM_READ) begin
            // Gather, beat data is the element index
            index    = ADDR_W'(beat.data);
            data_int = '0;
        end else begin
            // Scatter to the slot named by seq_id
            index    = ADDR_W'(beat.seq_id);
            data_int = beat.data;
        end
        addr_int = cfg.base_addr + (index << cfg.shift);
    end

    // ----------------------------------------------------------------------
    // Request register
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            req_valid <= 1'b0;
        end else begin
            req_valid <= take;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (take) begin
            req.op     <= cfg.op;
            req.addr   <= addr_int;
            req.data   <= data_int;
            req.seq_id <= beat.seq_id;
        end
    end

endmodule : rw_kernel

// ==== logic/rw_gen_control.sv ====
`timescale 1ns/1ps

module rw_gen_control
    import rw_gen_pkg::*;
(
    input  logic               ap_clk,
    input  logic               areset_generator,
    input  logic               cfg_valid,
    input  logic [COUNT_W-1:0] cfg_count,
    output logic               cfg_ready,
    input  logic               in_empty,
    input  logic               req_prog_full,
    input  logic               req_empty,
    input  logic               reads_zero,
    output logic               take,
    output logic               done
);

    gen_state_e         state;
    gen_state_e         state_next;
    logic [COUNT_W-1:0] remaining;
    logic               beats_left;
    logic               drained;

    assign beats_left = (remaining != '0);

    // Input queue included so no stray beat is left behind
    assign drained = req_empty & in_empty & reads_zero;

    // ----------------------------------------------------------------------
    // State register
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= GEN_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            GEN_IDLE: begin
                if (cfg_valid) begin
                    state_next = GEN_START;
                end
            end
            GEN_START: begin
                state_next = GEN_BUSY;
            end
            GEN_BUSY: begin
                if (!beats_left) begin
                    state_next = GEN_DRAIN;
                end else if (req_prog_full) begin
                    state_next = GEN_PAUSE;
                end
            end
            GEN_PAUSE: begin
                if (!req_prog_full) begin
                    state_next = GEN_BUSY;
                end
            end
            GEN_DRAIN: begin
                if (drained) begin
                    state_next = GEN_DONE;
                end
            end
            GEN_DONE: begin
                state_next = GEN_IDLE;
            end
            default: begin
                state_next = GEN_IDLE;
            end
        endcase
    end

    // ----------------------------------------------------------------------
    // Remaining beat counter
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            remaining <= '0;
        end else if (state == GEN_START) begin
            remaining <= cfg_count;
        end else if (take) begin
            remaining <= remaining - 1'b1;
        end
    end

    // Pop only with a beat waiting and room downstream
    assign take = (state == GEN_BUSY) & beats_left & ~in_empty & ~req_prog_full;

    assign cfg_ready = (state == GEN_IDLE);
    assign done      = (state == GEN_DONE);

    // No pop once the configured count has been taken
    assert property (@(posedge ap_clk) disable iff (areset_generator)
        take |-> (state == GEN_BUSY) && beats_left)
        else $error("rw_gen_control: take outside GEN_BUSY");

    // Nothing queued or in flight while done is high
    assert property (@(posedge ap_clk) disable iff (areset_generator)
        done |-> req_empty && reads_zero)
        else $error("rw_gen_control: done with requests or reads outstanding");

endmodule : rw_gen_control

// ==== logic/rw_gen_top.sv ====
`timescale 1ns/1ps

module rw_gen_top
    import rw_gen_pkg::*;
#(
    parameter int FIFO_DEPTH  = 16,
    parameter int PROG_THRESH = 8,
    parameter int CNT_W       = 8
) (
    input  logic         ap_clk,
    input  logic         areset_generator,
    input  gen_config_t  cfg,
    input  logic         cfg_valid,
    output logic         cfg_ready,
    input  engine_beat_t engine_in,
    input  logic         engine_in_valid,
    output logic         engine_in_ready,
    output mem_req_t     mem_req,
    output logic         mem_req_valid,
    input  logic         mem_req_ready,
    input  mem_resp_t    mem_resp,
    input  logic         mem_resp_valid,
    output logic         mem_resp_ready,
    output mem_resp_t    engine_out,
    output logic         engine_out_valid,
    input  logic         engine_out_ready,
    output logic         done
);

    gen_config_t  cfg_q;
    engine_beat_t in_head;
    logic         in_push;
    logic         in_empty;
    logic         in_full;
    logic         take;
    mem_req_t     kern_req;
    logic         kern_req_valid;
    logic         req_pop;
    logic         req_empty;
    logic         req_prog_full;
    logic         read_accept;
    logic         resp_accept;
    logic         cnt_zero;
    logic         reads_zero;
    mem_resp_t    resp_q;
    logic         resp_valid_q;

    // ----------------------------------------------------------------------
    // Configuration register
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (cfg_valid && cfg_ready) begin
            cfg_q <= cfg;
        end
    end

    // ----------------------------------------------------------------------
    // Beat path
    // ----------------------------------------------------------------------
    assign engine_in_ready = ~in_full;
    assign in_push         = engine_in_valid & ~in_full;

    packet_fifo #(
        .entry_t    (engine_beat_t),
        .FIFO_DEPTH (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH)
    ) in_fifo_i (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .din             (engine_in),
        .push            (in_push),
        .pop             (take),
        .dout            (in_head),
        .empty           (in_empty),
        .full            (in_full),
        .prog_full       ()
    );

    rw_kernel rw_kernel_i (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .cfg             (cfg_q),
        .beat            (in_head),
        .take            (take),
        .req             (kern_req),
        .req_valid       (kern_req_valid)
    );

    assign mem_req_valid = ~req_empty;
    assign req_pop       = mem_req_ready & ~req_empty;

    packet_fifo #(
        .entry_t    (mem_req_t),
        .FIFO_DEPTH (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH)
    ) req_fifo_i (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .din             (kern_req),
        .push            (kern_req_valid),
        .pop             (req_pop),
        .dout            (mem_req),
        .empty           (req_empty),
        .full            (),
        .prog_full       (req_prog_full)
    );

    // ----------------------------------------------------------------------
    // Reads in flight
    // ----------------------------------------------------------------------
    assign read_accept = req_pop & (mem_req.op == MEM_READ);
    assign resp_accept = mem_resp_valid & mem_resp_ready;

    outstanding_counter #(
        .CNT_W(CNT_W)
    ) outstanding_counter_i (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .incr            (read_accept),
        .decr            (resp_accept),
        .is_zero         (cnt_zero)
    );

    // Last response must also have left the output register
    assign reads_zero = cnt_zero & ~resp_valid_q;

    rw_gen_control rw_gen_control_i (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .cfg_valid       (cfg_valid),
        .cfg_count       (cfg_q.count),
        .cfg_ready       (cfg_ready),
        .in_empty        (in_empty),
        .req_prog_full   (req_prog_full),
        .req_empty       (req_empty),
        .reads_zero      (reads_zero),
        .take            (take),
        .done            (done)
    );

    // ----------------------------------------------------------------------
    // Response forwarding
    // ----------------------------------------------------------------------
    assign mem_resp_ready = ~resp_valid_q | engine_out_ready;

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            resp_valid_q <= 1'b0;
        end else if (resp_accept) begin
            resp_valid_q <= 1'b1;
        end else if (engine_out_ready) begin
            resp_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (resp_accept) begin
            resp_q <= mem_resp;
        end
    end

    assign engine_out       = resp_q;
    assign engine_out_valid = resp_valid_q;

endmodule : rw_gen_top

// ==== dv/tb_rw_gen.sv ====
`timescale 1ns/1ps

module tb_rw_gen
    import rw_gen_pkg::*;
();

    localparam int CLK_PERIOD     = 100;
    localparam int CYCLES_PER_LINE = 200;

    logic         ap_clk;
    logic         areset_generator;
    gen_config_t  cfg;
    logic         cfg_valid;
    logic         cfg_ready;
    engine_beat_t engine_in;
    logic         engine_in_valid;
    logic         engine_in_ready;
    mem_req_t     mem_req;
    logic         mem_req_valid;
    logic         mem_req_ready;
    mem_resp_t    mem_resp;
    logic         mem_resp_valid;
    logic         mem_resp_ready;
    mem_resp_t    engine_out;
    logic         engine_out_valid;
    logic         engine_out_ready;
    logic         done;

    // Stimulus and expected requests from the data file
    gen_config_t  cfg_list[$];
    int           cfg_end[$];
    engine_beat_t beat_list[$];
    mem_req_t     exp_req[$];
    int           n_lines;

    // Memory model
    mem_resp_t    pending[$];
    int           pending_due[$];
    mem_resp_t    sent[$];
    logic         resp_busy;
    int           cycle;
    int           delay;

    int           exp_idx;
    int           read_count;
    int           fwd_count;
    int           done_count;
    int           errors;
    int           tests_passed;
    int           tests_failed;
    logic         in_cfg;
    logic         stalls_on;
    integer       seed;
    logic [31:0]  rnd;
    logic [31:0]  rnd_delay;
    mem_req_t     want;
    mem_resp_t    got;
    mem_resp_t    next_resp;

    rw_gen_top dut_i (.*);

    initial begin
        ap_clk = 1'b0;
        forever #(CLK_PERIOD / 2) ap_clk = ~ap_clk;
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("Fail %s: expected %h, actual %h", name, expected, actual);
        errors++;
    endtask

    task automatic note_failure(input string what);
        $display("%s", what);
        errors++;
    endtask

    task automatic log_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("test %s: passed", name);
            tests_passed++;
        end else begin
            $display("test %s: failed with %0d errors", name, errors - errs_before);
            tests_failed++;
        end
    endtask

    // ----------------------------------------------------------------------
    // Data file
    // ----------------------------------------------------------------------
    task automatic load_input();
        integer       fd;
        integer       n;
        string        line;
        logic [7:0]   kind;
        logic [31:0]  f1;
        logic [31:0]  f2;
        logic [31:0]  f3;
        logic [31:0]  f4;
        logic [31:0]  rule_addr;
        logic [31:0]  rule_data;
        gen_config_t  cur;
        engine_beat_t b;
        mem_req_t     req;
        fd = $fopen("dv/rw_gen_input.txt", "r");
        if (fd == 0) begin
            note_failure("Could not open dv/rw_gen_input.txt");
            return;
        end
        cur = '0;
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n == 0) break;
            n_lines++;
            if (line.len() < 2 || line[0] == "#") continue;
            n = $sscanf(line, "%c %h %h %h %h", kind, f1, f2, f3, f4);
            if (kind == "C") begin
                if (cfg_end.size() > 0 && cfg_end[cfg_end.size() - 1] != beat_list.size()) begin
                    note_failure("Beat count in the data file does not match its configuration");
                end
                cur.base_addr = f1;
                cur.shift     = f2[1:0];
                cur.op        = f3[0] ? MEM_WRITE : MEM_READ;
                cur.count     = f4[15:0];
                cfg_list.push_back(cur);
                cfg_end.push_back(beat_list.size() + int'(cur.count));
            end else if (kind == "B") begin
                b.data   = f1;
                b.seq_id = f2[7:0];
                beat_list.push_back(b);
                // Gather indexes by data, scatter by seq_id
                if (cur.op == MEM_READ) begin
                    rule_addr = cur.base_addr + (f1 << cur.shift);
                    rule_data = 32'd0;
                end else begin
                    rule_addr = cur.base_addr + ({24'd0, f2[7:0]} << cur.shift);
                    rule_data = f1;
                end
                if (f3 !== rule_addr || f4 !== rule_data) begin
                    note_failure($sformatf("Data file line %0d breaks the address rule", n_lines));
                end
                req.op     = cur.op;
                req.addr   = f3;
                req.data   = f4;
                req.seq_id = f2[7:0];
                exp_req.push_back(req);
            end else begin
                note_failure($sformatf("Data file line %0d is not understood", n_lines));
            end
        end
        if (cfg_end.size() > 0 && cfg_end[cfg_end.size() - 1] != beat_list.size()) begin
            note_failure("Beat count in the data file does not match its configuration");
        end
        $fclose(fd);
    endtask

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------
    initial begin
        int    k;
        int    i;
        int    first;
        int    errs_before;
        string name;
        seed             = 32'h4b3ade20;
        areset_generator = 1'b1;
        cfg              = '0;
        cfg_valid        = 1'b0;
        engine_in        = '0;
        engine_in_valid  = 1'b0;
        mem_req_ready    = 1'b1;
        mem_resp         = '0;
        mem_resp_valid   = 1'b0;
        engine_out_ready = 1'b1;
        resp_busy        = 1'b0;
        in_cfg           = 1'b0;
        stalls_on        = 1'b0;
        cycle            = 0;
        load_input();

        repeat (3) @(posedge ap_clk);
        areset_generator <= 1'b0;

        errs_before = errors;
        @(posedge ap_clk);
        if (cfg_ready !== 1'b1) report_mismatch("cfg_ready", 32'd1, 32'(cfg_ready));
        if (mem_req_valid !== 1'b0) report_mismatch("mem_req_valid", 32'd0, 32'(mem_req_valid));
        if (engine_out_valid !== 1'b0) begin
            report_mismatch("engine_out_valid", 32'd0, 32'(engine_out_valid));
        end
        if (done !== 1'b0) report_mismatch("done", 32'd0, 32'(done));
        log_test("reset state", errs_before);

        first = 0;
        if (errors == 0) begin
            for (k = 0; k < cfg_list.size(); k++) begin
                errs_before = errors;
                stalls_on <= (k >= 2);
                cfg       <= cfg_list[k];
                cfg_valid <= 1'b1;
                @(posedge ap_clk);
                while (!cfg_ready) @(posedge ap_clk);
                cfg_valid <= 1'b0;
                for (i = first; i < cfg_end[k]; i++) begin
                    engine_in       <= beat_list[i];
                    engine_in_valid <= 1'b1;
                    @(posedge ap_clk);
                    while (!engine_in_ready) @(posedge ap_clk);
                end
                engine_in_valid <= 1'b0;
                first = cfg_end[k];
                @(posedge ap_clk);
                while (!done) @(posedge ap_clk);
                @(posedge ap_clk);
                name = $sformatf("%0d %s%s", k,
                                 (cfg_list[k].op == MEM_READ) ? "gather" : "scatter",
                                 (k >= 2) ? " with stalls" : "");
                log_test(name, errs_before);
            end
        end

        if (done_count != cfg_list.size()) note_failure("Done pulse count differs from configs");
        if (exp_idx != exp_req.size()) note_failure("Not every expected request reached mem_req");
        if (fwd_count != read_count) note_failure("Forwarded responses differ from reads");
        $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // ----------------------------------------------------------------------
    // Memory model and checks
    // ----------------------------------------------------------------------
    always @(posedge ap_clk) begin
        rnd = $random(seed);
        if (stalls_on) begin
            mem_req_ready    <= (rnd[1:0] == 2'd0);
            engine_out_ready <= rnd[4];
        end else begin
            mem_req_ready    <= 1'b1;
            engine_out_ready <= 1'b1;
        end
        if (!areset_generator) begin
            cycle++;
            if (mem_req_valid && mem_req_ready) begin
                if (exp_idx >= exp_req.size()) begin
                    note_failure("mem_req transfer with no expected request left");
                end else begin
                    want = exp_req[exp_idx];
                    if (mem_req.op !== want.op) begin
                        report_mismatch("mem_req.op", 32'(want.op), 32'(mem_req.op));
                    end
                    if (mem_req.addr !== want.addr) begin
                        report_mismatch("mem_req.addr", want.addr, mem_req.addr);
                    end
                    if (mem_req.data !== want.data) begin
                        report_mismatch("mem_req.data", want.data, mem_req.data);
                    end
                    if (mem_req.seq_id !== want.seq_id) begin
                        report_mismatch("mem_req.seq_id", 32'(want.seq_id), 32'(mem_req.seq_id));
                    end
                    exp_idx++;
                end
                // Reads get an answer 0 to 5 cycles later
                if (mem_req.op == MEM_READ) begin
                    rnd_delay        = $random(seed);
                    delay            = int'(rnd_delay % 32'd6);
                    next_resp.addr   = mem_req.addr;
                    next_resp.data   = mem_req.addr ^ 32'h5a5a5a5a;
                    next_resp.seq_id = mem_req.seq_id;
                    pending.push_back(next_resp);
                    pending_due.push_back(cycle + delay);
                    read_count++;
                end
            end

            if (engine_out_valid && engine_out_ready) begin
                if (sent.size() == 0) begin
                    note_failure("engine_out transfer with no response sent");
                end else begin
                    got = sent.pop_front();
                    if (engine_out.addr !== got.addr) begin
                        report_mismatch("engine_out.addr", got.addr, engine_out.addr);
                    end
                    if (engine_out.data !== got.data) begin
                        report_mismatch("engine_out.data", got.data, engine_out.data);
                    end
                    if (engine_out.seq_id !== got.seq_id) begin
                        report_mismatch("engine_out.seq_id", 32'(got.seq_id),
                                        32'(engine_out.seq_id));
                    end
                    fwd_count++;
                end
            end

            if (mem_resp_valid && mem_resp_ready) begin
                sent.push_back(mem_resp);
                resp_busy = 1'b0;
            end
            if (!resp_busy) begin
                if (pending.size() > 0 && pending_due[0] <= cycle) begin
                    mem_resp       <= pending.pop_front();
                    pending_due.delete(0);
                    mem_resp_valid <= 1'b1;
                    resp_busy = 1'b1;
                end else begin
                    mem_resp_valid <= 1'b0;
                end
            end

            if (in_cfg && cfg_ready) note_failure("cfg_ready high while a configuration runs");
            if (done) begin
                if (!in_cfg) note_failure("done pulse with no configuration in progress");
                if (done_count < cfg_end.size() && exp_idx != cfg_end[done_count]) begin
                    note_failure("done before every request of the configuration was seen");
                end
                if (pending.size() != 0 || sent.size() != 0 || resp_busy) begin
                    note_failure("done before the last read response was forwarded");
                end
                done_count++;
                in_cfg = 1'b0;
            end
            if (cfg_valid && cfg_ready) in_cfg = 1'b1;
        end
    end

    // Ends a hung run
    initial begin
        wait (n_lines > 0);
        #(n_lines * CYCLES_PER_LINE * CLK_PERIOD);
        $display("Timeout after %0d cycles with the run still going", n_lines * CYCLES_PER_LINE);
        $display(">>> FAIL");
        $finish;
    end

endmodule : tb_rw_gen

// ==== list.f ====
logic/rw_gen_pkg.sv
logic/packet_fifo.sv
logic/outstanding_counter.sv
logic/rw_kernel.sv
logic/rw_gen_control.sv
logic/rw_gen_top.sv
dv/tb_rw_gen.sv

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_rw_gen -f list.f -o tb_rw_gen

./obj_dir/tb_rw_gen > sim.log || true
cat sim.log

if grep -qx ">>> PASS" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

// ==== dv/rw_gen_input.txt ====
# C base_addr shift op count (hex, op 0 is read and 1 is write)
# B data seq_id expected_addr expected_data (hex)
C 00001000 2 0 0004
B 00000003 01 0000100c 00000000
B 00000010 02 00001040 00000000
B 00000000 03 00001000 00000000
B 000000ff 04 000013fc 00000000
C 20000000 3 1 0004
B deadbeef 00 20000000 deadbeef
B 12345678 05 20000028 12345678
B cafef00d 10 20000080 cafef00d
B 0badc0de ff 200007f8 0badc0de
C 00400000 1 0 000a
B 00000000 10 00400000 00000000
B 00000001 11 00400002 00000000
B 00000002 12 00400004 00000000
B 00000100 13 00400200 00000000
B 00001000 14 00402000 00000000
B 0000abcd 15 0041579a 00000000
B 00000007 16 0040000e 00000000
B 00000020 17 00400040 00000000
B 00000fff 18 00401ffe 00000000
B 00000033 19 00400066 00000000
C 80000000 0 1 0004
B 11111111 01 80000001 11111111
B 22222222 02 80000002 22222222
B 33333333 7f 8000007f 33333333
B 44444444 80 80000080 44444444
